// ==== logic/slv_switch_settings.svh ====
/*
 * Slave switch settings: bus widths, slave count and the fixed address map
 */
`ifndef SLV_SWITCH_SETTINGS_SVH
`define SLV_SWITCH_SETTINGS_SVH

// Bus widths
`define ADDR_W 8
`define ID_W 4
`define DATA_W 8

// Slave count and reachable slaves, slave 3 is off limits
`define SLV_NB 4
`define SLV_ROUTES 4'b0111

// Address map, 8'hB0 to 8'hBF is left unmapped
`define SLV0_START 8'h00
`define SLV0_END 8'h3F
`define SLV1_START 8'h40
`define SLV1_END 8'h7F
`define SLV2_START 8'h80
`define SLV2_END 8'hAF
`define SLV3_START 8'hC0
`define SLV3_END 8'hFF

// Queue depths
`define TGT_FIFO_DEPTH 8
`define ERR_FIFO_DEPTH 4

`endif

// ==== logic/slv_switch_pkg.sv ====
/*
 * Slave switch types: AXI4-lite fields, slave masks and response beats
 */
`default_nettype none

`include "slv_switch_settings.svh"

package slv_switch_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`ID_W-1:0] id_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [1:0] resp_t;

    // One bit per slave port
    typedef logic [`SLV_NB-1:0] slv_mask_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // Beats keep id on top and resp below it,
    // any payload sits in the low bits
    typedef struct packed {
        id_t id;
        resp_t resp;
    } b_beat_t;

    typedef struct packed {
        id_t id;
        resp_t resp;
        data_t data;
    } r_beat_t;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
/*
 * Single-clock FIFO, circular buffer with the front entry on the output
 */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type T = logic [7:0],
    // Power of two, at least 2
    parameter int DEPTH = 4
) (
    input  wire   aclk,
    input  wire   aresetn,
    input  wire   i_push,
    input  wire T i_data,
    output logic  o_full,
    input  wire   i_pop,
    output T      o_data,
    output logic  o_empty
);

    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];
    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push && !o_full)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_pop && !o_empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_push && !o_full)
            mem[wr_ptr[AW-1:0]] <= i_data;
    end

    assert property (@(posedge aclk) disable iff (!aresetn) i_push |-> !o_full)
        else $error("push into a full FIFO");
    assert property (@(posedge aclk) disable iff (!aresetn) i_pop |-> !o_empty)
        else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
/*
 * Round-robin arbiter over the slave requests with a rotating start pointer
 */
`timescale 1ns/100ps
`default_nettype none

`include "slv_switch_settings.svh"

module rr_arbiter
    import slv_switch_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,
    input  wire slv_mask_t i_req,
    input  wire            i_advance,
    output slv_mask_t      o_grant
);

    localparam int IDX_W = $clog2(`SLV_NB);

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] grant_idx;
    logic found;

    // First requester at or after the pointer
    always_comb begin
        o_grant = '0;
        grant_idx = ptr;
        found = 1'b0;
        for (int k = 0; k < `SLV_NB; k++) begin
            if (!found && i_req[(int'(ptr) + k) % `SLV_NB]) begin
                found = 1'b1;
                grant_idx = IDX_W'((int'(ptr) + k) % `SLV_NB);
            end
        end
        if (found)
            o_grant[grant_idx] = 1'b1;
    end

    // Park on a pending grant so a late requester cannot displace it
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ptr <= '0;
        end else if (i_advance) begin
            ptr <= (grant_idx == IDX_W'(`SLV_NB - 1)) ? '0 : grant_idx + 1'b1;
        end else if (found) begin
            ptr <= grant_idx;
        end
    end

    // A grant that is not taken stays with its waiting requester
    assert property (@(posedge aclk) disable iff (!aresetn)
        (|o_grant) && !i_advance |=>
            !(|(i_req & $past(o_grant))) || (o_grant == $past(o_grant)))
        else $error("grant moved away from a waiting requester");

endmodule

`default_nettype wire

// ==== logic/addr_router.sv ====
/*
 * Address channel router: decodes the slave, steers valid, returns ready
 * and fakes a handshake for unmapped or forbidden addresses
 */
`timescale 1ns/100ps
`default_nettype none

`include "slv_switch_settings.svh"

module addr_router
    import slv_switch_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,
    input  wire            i_valid,
    output logic           o_ready,
    input  wire addr_t     i_addr,
    input  wire            i_push_ok,
    output slv_mask_t      o_s_valid,
    input  wire slv_mask_t i_s_ready,
    output slv_mask_t      o_target,
    output logic           o_err_push
);

    localparam addr_t SLV_START [`SLV_NB] =
        '{`SLV0_START, `SLV1_START, `SLV2_START, `SLV3_START};
    localparam addr_t SLV_END [`SLV_NB] =
        '{`SLV0_END, `SLV1_END, `SLV2_END, `SLV3_END};
    localparam slv_mask_t ROUTES = `SLV_ROUTES;

    logic routed;
    logic err_pulse;

    // Range check, only on slaves this master may reach
    always_comb begin
        for (int i = 0; i < `SLV_NB; i++) begin
            o_target[i] = ROUTES[i] && (i_addr >= SLV_START[i]) && (i_addr <= SLV_END[i]);
        end
    end

    assign routed = |o_target;
    assign o_s_valid = o_target & {`SLV_NB{i_valid & i_push_ok}};
    assign o_ready = routed ? (|(i_s_ready & o_target)) & i_push_ok : err_pulse;
    assign o_err_push = err_pulse;

    // One-cycle fake ready, the cycle after a misrouted valid
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            err_pulse <= 1'b0;
        end else if (err_pulse) begin
            err_pulse <= 1'b0;
        end else if (i_valid && !routed && i_push_ok) begin
            err_pulse <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wdata_steer.sv ====
/*
 * Write data steering: each beat follows the slave of its own address,
 * data for a misrouted address is taken and dropped
 */
`timescale 1ns/100ps
`default_nettype none

`include "slv_switch_settings.svh"

module wdata_steer
    import slv_switch_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,
    input  wire            i_aw_accept,
    input  wire slv_mask_t i_target,
    output logic           o_tgt_full,
    input  wire            i_wvalid,
    output logic           o_wready,
    output slv_mask_t      o_s_wvalid,
    input  wire slv_mask_t i_s_wready
);

    slv_mask_t front;
    logic tgt_empty;
    logic drop;

    // Targets in address order, zero mask for a misroute
    sync_fifo #(
        .T     (slv_mask_t),
        .DEPTH (`TGT_FIFO_DEPTH)
    ) tgt_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (i_aw_accept),
        .i_data  (i_target),
        .o_full  (o_tgt_full),
        .i_pop   (i_wvalid & o_wready),
        .o_data  (front),
        .o_empty (tgt_empty)
    );

    assign drop = (front == '0);
    assign o_s_wvalid = front & {`SLV_NB{i_wvalid & ~tgt_empty}};
    assign o_wready = ~tgt_empty & (drop | (|(front & i_s_wready)));

endmodule

`default_nettype wire

// ==== logic/resp_merger.sv ====
/*
 * Response merger: queued DECERR beats first, then the slave responses
 * in round-robin order onto the single master channel
 */
`timescale 1ns/100ps
`default_nettype none

`include "slv_switch_settings.svh"

module resp_merger
    import slv_switch_pkg::*;
#(
    parameter type T = b_beat_t
) (
    input  wire                 aclk,
    input  wire                 aresetn,
    input  wire                 i_err_push,
    input  wire id_t            i_err_id,
    output logic                o_err_full,
    input  wire slv_mask_t      i_s_valid,
    output slv_mask_t           o_s_ready,
    input  wire T [`SLV_NB-1:0] i_s_beat,
    output logic                o_valid,
    input  wire                 i_ready,
    output T                    o_beat
);

    localparam int BEAT_W = $bits(T);
    localparam int PAD_W = BEAT_W - $bits(id_t) - $bits(resp_t);

    id_t err_id;
    logic err_empty;
    logic err_sel;
    logic slv_hold;
    logic slv_valid;
    slv_mask_t grant;
    T slv_beat;
    logic [BEAT_W-1:0] err_bits;

    //////////////////////////////////////////////////
    // Error IDs and slave arbitration
    //////////////////////////////////////////////////

    sync_fifo #(
        .T     (id_t),
        .DEPTH (`ERR_FIFO_DEPTH)
    ) err_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (i_err_push),
        .i_data  (i_err_id),
        .o_full  (o_err_full),
        .i_pop   (err_sel & i_ready),
        .o_data  (err_id),
        .o_empty (err_empty)
    );

    rr_arbiter arbiter (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_req     (i_s_valid),
        .i_advance (|(i_s_valid & o_s_ready)),
        .o_grant   (grant)
    );

    //////////////////////////////////////////////////
    // Output selection
    //////////////////////////////////////////////////

    // A slave beat already on the bus finishes before an error beat
    assign err_sel = ~err_empty & ~slv_hold;
    assign slv_valid = |(i_s_valid & grant);
    assign o_valid = err_sel | slv_valid;
    assign o_s_ready = grant & {`SLV_NB{i_ready & ~err_sel}};

    always_comb begin
        slv_beat = '0;
        for (int i = 0; i < `SLV_NB; i++) begin
            if (grant[i])
                slv_beat = i_s_beat[i];
        end
    end

    // DECERR beat, id and resp on top, payload zero
    assign err_bits = BEAT_W'({err_id, RESP_DECERR}) << PAD_W;
    assign o_beat = err_sel ? T'(err_bits) : slv_beat;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            slv_hold <= 1'b0;
        else
            slv_hold <= slv_valid & ~err_sel & ~i_ready;
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        o_valid && !i_ready |=> o_valid && $stable(o_beat))
        else $error("response beat changed under back-pressure");

endmodule

`default_nettype wire

// ==== logic/slv_switch_top.sv ====
/*
 * AXI4-lite slave switch: routes one master port to four slave ports
 * and answers misrouted requests with DECERR
 */
`timescale 1ns/100ps
`default_nettype none

`include "slv_switch_settings.svh"

module slv_switch_top
    import slv_switch_pkg::*;
(
    input  wire                        aclk,
    input  wire                        aresetn,
    // Master write address
    input  wire                        i_awvalid,
    output logic                       o_awready,
    input  wire addr_t                 i_awaddr,
    input  wire id_t                   i_awid,
    // Master write data
    input  wire                        i_wvalid,
    output logic                       o_wready,
    input  wire data_t                 i_wdata,
    // Master write response
    output logic                       o_bvalid,
    input  wire                        i_bready,
    output id_t                        o_bid,
    output resp_t                      o_bresp,
    // Master read address
    input  wire                        i_arvalid,
    output logic                       o_arready,
    input  wire addr_t                 i_araddr,
    input  wire id_t                   i_arid,
    // Master read response
    output logic                       o_rvalid,
    input  wire                        i_rready,
    output id_t                        o_rid,
    output resp_t                      o_rresp,
    output data_t                      o_rdata,
    // Slave side
    output slv_mask_t                  o_s_awvalid,
    input  wire slv_mask_t             i_s_awready,
    output addr_t                      o_s_awaddr,
    output id_t                        o_s_awid,
    output slv_mask_t                  o_s_wvalid,
    input  wire slv_mask_t             i_s_wready,
    output data_t                      o_s_wdata,
    input  wire slv_mask_t             i_s_bvalid,
    output slv_mask_t                  o_s_bready,
    input  wire b_beat_t [`SLV_NB-1:0] i_s_bbeat,
    output slv_mask_t                  o_s_arvalid,
    input  wire slv_mask_t             i_s_arready,
    output addr_t                      o_s_araddr,
    output id_t                        o_s_arid,
    input  wire slv_mask_t             i_s_rvalid,
    output slv_mask_t                  o_s_rready,
    input  wire r_beat_t [`SLV_NB-1:0] i_s_rbeat
);

    slv_mask_t aw_target;
    logic aw_err_push;
    logic ar_err_push;
    logic tgt_full;
    logic b_err_full;
    logic r_err_full;
    b_beat_t b_beat;
    r_beat_t r_beat;

    // Address, id and data go to every slave, valids pick one
    assign o_s_awaddr = i_awaddr;
    assign o_s_awid = i_awid;
    assign o_s_wdata = i_wdata;
    assign o_s_araddr = i_araddr;
    assign o_s_arid = i_arid;

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    addr_router aw_router (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_valid    (i_awvalid),
        .o_ready    (o_awready),
        .i_addr     (i_awaddr),
        .i_push_ok  (~tgt_full & ~b_err_full),
        .o_s_valid  (o_s_awvalid),
        .i_s_ready  (i_s_awready),
        .o_target   (aw_target),
        .o_err_push (aw_err_push)
    );

    wdata_steer w_steer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_aw_accept (i_awvalid & o_awready),
        .i_target    (aw_target),
        .o_tgt_full  (tgt_full),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_s_wvalid  (o_s_wvalid),
        .i_s_wready  (i_s_wready)
    );

    resp_merger #(.T(b_beat_t)) b_merger (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_err_push (aw_err_push),
        .i_err_id   (i_awid),
        .o_err_full (b_err_full),
        .i_s_valid  (i_s_bvalid),
        .o_s_ready  (o_s_bready),
        .i_s_beat   (i_s_bbeat),
        .o_valid    (o_bvalid),
        .i_ready    (i_bready),
        .o_beat     (b_beat)
    );

    assign o_bid = b_beat.id;
    assign o_bresp = b_beat.resp;

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    addr_router ar_router (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_valid    (i_arvalid),
        .o_ready    (o_arready),
        .i_addr     (i_araddr),
        .i_push_ok  (~r_err_full),
        .o_s_valid  (o_s_arvalid),
        .i_s_ready  (i_s_arready),
        .o_target   (),
        .o_err_push (ar_err_push)
    );

    resp_merger #(.T(r_beat_t)) r_merger (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_err_push (ar_err_push),
        .i_err_id   (i_arid),
        .o_err_full (r_err_full),
        .i_s_valid  (i_s_rvalid),
        .o_s_ready  (o_s_rready),
        .i_s_beat   (i_s_rbeat),
        .o_valid    (o_rvalid),
        .i_ready    (i_rready),
        .o_beat     (r_beat)
    );

    assign o_rid = r_beat.id;
    assign o_rresp = r_beat.resp;
    assign o_rdata = r_beat.data;

endmodule

`default_nettype wire

// ==== tests/slv_switch_tb.sv ====
/*
 * Slave switch testbench: four behavioral slaves, directed write, read,
 * misroute, merge and back-pressure tests against the fixed address map
 */
`timescale 1ns/100ps
`default_nettype none

`include "slv_switch_settings.svh"

module slv_switch_tb
    import slv_switch_pkg::*;
();

    localparam int WAIT_LIMIT = 100;
    // One address in each of slaves 0, 1 and 2, index equals slave
    localparam addr_t WR_ADDR [3] = '{8'h10, 8'h55, 8'h9A};
    // Hole, then forbidden slave 3
    localparam addr_t BAD_WR_ADDR [2] = '{8'hB0, 8'hC4};
    localparam addr_t BAD_RD_ADDR [2] = '{8'hB8, 8'hF0};

    logic aclk;
    logic aresetn = 1'b1;
    integer seed;

    // Master side
    logic awvalid;
    logic awready;
    addr_t awaddr;
    id_t awid;
    logic wvalid;
    logic wready;
    data_t wdata;
    logic bvalid;
    logic bready;
    id_t bid;
    resp_t bresp;
    logic arvalid;
    logic arready;
    addr_t araddr;
    id_t arid;
    logic rvalid;
    logic rready;
    id_t rid;
    resp_t rresp;
    data_t rdata;

    // Slave side
    slv_mask_t s_awvalid;
    slv_mask_t s_awready;
    addr_t s_awaddr;
    id_t s_awid;
    slv_mask_t s_wvalid;
    slv_mask_t s_wready;
    data_t s_wdata;
    slv_mask_t s_bvalid;
    slv_mask_t s_bready;
    b_beat_t [`SLV_NB-1:0] s_bbeat;
    slv_mask_t s_arvalid;
    slv_mask_t s_arready;
    addr_t s_araddr;
    id_t s_arid;
    slv_mask_t s_rvalid;
    slv_mask_t s_rready;
    r_beat_t [`SLV_NB-1:0] s_rbeat;

    // Slave model state
    data_t slv_mem [`SLV_NB][256];
    slv_mask_t aw_got;
    slv_mask_t w_got;
    slv_mask_t b_hold;
    addr_t aw_addr_q [`SLV_NB];
    id_t aw_id_q [`SLV_NB];
    data_t w_data_q [`SLV_NB];
    int aw_cnt [`SLV_NB] = '{default: 0};
    int w_cnt [`SLV_NB] = '{default: 0};
    int ar_cnt [`SLV_NB] = '{default: 0};
    int aw_base [`SLV_NB];
    int w_base [`SLV_NB];
    int ar_base [`SLV_NB];
    id_t wr_id [3];
    data_t wr_data [3];

    slv_switch_top slv_switch_top_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_awvalid   (awvalid),
        .o_awready   (awready),
        .i_awaddr    (awaddr),
        .i_awid      (awid),
        .i_wvalid    (wvalid),
        .o_wready    (wready),
        .i_wdata     (wdata),
        .o_bvalid    (bvalid),
        .i_bready    (bready),
        .o_bid       (bid),
        .o_bresp     (bresp),
        .i_arvalid   (arvalid),
        .o_arready   (arready),
        .i_araddr    (araddr),
        .i_arid      (arid),
        .o_rvalid    (rvalid),
        .i_rready    (rready),
        .o_rid       (rid),
        .o_rresp     (rresp),
        .o_rdata     (rdata),
        .o_s_awvalid (s_awvalid),
        .i_s_awready (s_awready),
        .o_s_awaddr  (s_awaddr),
        .o_s_awid    (s_awid),
        .o_s_wvalid  (s_wvalid),
        .i_s_wready  (s_wready),
        .o_s_wdata   (s_wdata),
        .i_s_bvalid  (s_bvalid),
        .o_s_bready  (s_bready),
        .i_s_bbeat   (s_bbeat),
        .o_s_arvalid (s_arvalid),
        .i_s_arready (s_arready),
        .o_s_araddr  (s_araddr),
        .o_s_arid    (s_arid),
        .i_s_rvalid  (s_rvalid),
        .o_s_rready  (s_rready),
        .i_s_rbeat   (s_rbeat)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // Slave models
    //////////////////////////////////////////////////

    // Readies always high, B once address and data are both in
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s_awready <= '0;
            s_wready <= '0;
            s_arready <= '0;
            s_bvalid <= '0;
            s_rvalid <= '0;
            s_bbeat <= '0;
            s_rbeat <= '0;
            aw_got <= '0;
            w_got <= '0;
        end else begin
            s_awready <= '1;
            s_wready <= '1;
            s_arready <= '1;
            for (int s = 0; s < `SLV_NB; s++) begin
                if (s_bvalid[s] && s_bready[s])
                    s_bvalid[s] <= 1'b0;
                if (aw_got[s] && w_got[s] && !s_bvalid[s] && !b_hold[s]) begin
                    slv_mem[s][aw_addr_q[s]] <= w_data_q[s];
                    s_bbeat[s].id <= aw_id_q[s];
                    s_bbeat[s].resp <= RESP_OKAY;
                    s_bvalid[s] <= 1'b1;
                    aw_got[s] <= 1'b0;
                    w_got[s] <= 1'b0;
                end
                if (s_awvalid[s] && s_awready[s]) begin
                    aw_got[s] <= 1'b1;
                    aw_addr_q[s] <= s_awaddr;
                    aw_id_q[s] <= s_awid;
                    aw_cnt[s] <= aw_cnt[s] + 1;
                end
                if (s_wvalid[s] && s_wready[s]) begin
                    w_got[s] <= 1'b1;
                    w_data_q[s] <= s_wdata;
                    w_cnt[s] <= w_cnt[s] + 1;
                end
                if (s_rvalid[s] && s_rready[s])
                    s_rvalid[s] <= 1'b0;
                if (s_arvalid[s] && s_arready[s]) begin
                    s_rbeat[s].id <= s_arid;
                    s_rbeat[s].resp <= RESP_OKAY;
                    s_rbeat[s].data <= slv_mem[s][s_araddr];
                    s_rvalid[s] <= 1'b1;
                    ar_cnt[s] <= ar_cnt[s] + 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks and bus tasks
    //////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s did not arrive within %0d cycles",
                 $time, what, WAIT_LIMIT);
        $display("Test FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic snapshot_counts();
        aw_base = aw_cnt;
        w_base = w_cnt;
        ar_base = ar_cnt;
    endtask

    // Valid cycles seen per slave since the snapshot, tgt of -1 means none
    task automatic check_slave_hits(input int tgt, input int n_aw, input int n_w,
                                    input int n_ar);
        int hit;
        for (int s = 0; s < `SLV_NB; s++) begin
            hit = (s == tgt) ? 1 : 0;
            compare_value($sformatf("o_s_awvalid[%0d] count", s),
                          32'(aw_cnt[s] - aw_base[s]), 32'(hit * n_aw));
            compare_value($sformatf("o_s_wvalid[%0d] count", s),
                          32'(w_cnt[s] - w_base[s]), 32'(hit * n_w));
            compare_value($sformatf("o_s_arvalid[%0d] count", s),
                          32'(ar_cnt[s] - ar_base[s]), 32'(hit * n_ar));
        end
    endtask

    task automatic drive_aw(input addr_t addr, input id_t id);
        int n;
        n = 0;
        awvalid <= 1'b1;
        awaddr <= addr;
        awid <= id;
        do begin
            @(posedge aclk);
            n++;
        end while (!awready && n < WAIT_LIMIT);
        if (!awready)
            stop_on_timeout("write address ready");
        awvalid <= 1'b0;
    endtask

    task automatic drive_w(input data_t data);
        int n;
        n = 0;
        wvalid <= 1'b1;
        wdata <= data;
        do begin
            @(posedge aclk);
            n++;
        end while (!wready && n < WAIT_LIMIT);
        if (!wready)
            stop_on_timeout("write data ready");
        wvalid <= 1'b0;
    endtask

    task automatic drive_ar(input addr_t addr, input id_t id);
        int n;
        n = 0;
        arvalid <= 1'b1;
        araddr <= addr;
        arid <= id;
        do begin
            @(posedge aclk);
            n++;
        end while (!arready && n < WAIT_LIMIT);
        if (!arready)
            stop_on_timeout("read address ready");
        arvalid <= 1'b0;
    endtask

    task automatic collect_b(output id_t id, output resp_t resp);
        int n;
        n = 0;
        bready <= 1'b1;
        do begin
            @(posedge aclk);
            n++;
        end while (!bvalid && n < WAIT_LIMIT);
        if (!bvalid)
            stop_on_timeout("write response");
        id = bid;
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic collect_r(output id_t id, output resp_t resp, output data_t data);
        int n;
        n = 0;
        rready <= 1'b1;
        do begin
            @(posedge aclk);
            n++;
        end while (!rvalid && n < WAIT_LIMIT);
        if (!rvalid)
            stop_on_timeout("read response");
        id = rid;
        resp = rresp;
        data = rdata;
        rready <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic routed_writes();
        id_t id;
        resp_t resp;
        for (int k = 0; k < 3; k++) begin
            wr_id[k] = id_t'($random(seed));
            wr_data[k] = data_t'($random(seed));
            snapshot_counts();
            drive_aw(WR_ADDR[k], wr_id[k]);
            drive_w(wr_data[k]);
            collect_b(id, resp);
            compare_value("o_bid", 32'(id), 32'(wr_id[k]));
            compare_value("o_bresp", 32'(resp), 32'(RESP_OKAY));
            compare_value($sformatf("slave %0d memory", k),
                          32'(slv_mem[k][WR_ADDR[k]]), 32'(wr_data[k]));
            check_slave_hits(k, 1, 1, 0);
        end
    endtask

    task automatic routed_reads();
        id_t id;
        id_t got_id;
        resp_t resp;
        data_t data;
        for (int k = 0; k < 3; k++) begin
            id = id_t'($random(seed));
            snapshot_counts();
            drive_ar(WR_ADDR[k], id);
            collect_r(got_id, resp, data);
            compare_value("o_rid", 32'(got_id), 32'(id));
            compare_value("o_rresp", 32'(resp), 32'(RESP_OKAY));
            compare_value("o_rdata", 32'(data), 32'(wr_data[k]));
            check_slave_hits(k, 0, 0, 1);
        end
    endtask

    task automatic misrouted_writes();
        id_t id;
        id_t got_id;
        resp_t resp;
        for (int k = 0; k < 2; k++) begin
            id = id_t'($random(seed));
            snapshot_counts();
            drive_aw(BAD_WR_ADDR[k], id);
            drive_w(data_t'($random(seed)));
            collect_b(got_id, resp);
            compare_value("o_bid", 32'(got_id), 32'(id));
            compare_value("o_bresp", 32'(resp), 32'(RESP_DECERR));
            check_slave_hits(-1, 0, 0, 0);
        end
    endtask

    task automatic misrouted_reads();
        id_t id;
        id_t got_id;
        resp_t resp;
        data_t data;
        for (int k = 0; k < 2; k++) begin
            id = id_t'($random(seed));
            snapshot_counts();
            drive_ar(BAD_RD_ADDR[k], id);
            collect_r(got_id, resp, data);
            compare_value("o_rid", 32'(got_id), 32'(id));
            compare_value("o_rresp", 32'(resp), 32'(RESP_DECERR));
            compare_value("o_rdata", 32'(data), 32'd0);
            check_slave_hits(-1, 0, 0, 0);
        end
    endtask

    // Slaves 0 and 2 hold their B until both writes are in
    task automatic merged_responses();
        id_t id0;
        id_t id2;
        id_t got_a;
        id_t got_b;
        resp_t resp_a;
        resp_t resp_b;
        id0 = id_t'($random(seed));
        id2 = id0 + 1'b1;
        b_hold <= 4'b0101;
        drive_aw(8'h20, id0);
        drive_aw(8'h84, id2);
        drive_w(data_t'($random(seed)));
        drive_w(data_t'($random(seed)));
        b_hold <= '0;
        collect_b(got_a, resp_a);
        collect_b(got_b, resp_b);
        compare_value("o_bresp", 32'(resp_a), 32'(RESP_OKAY));
        compare_value("o_bresp", 32'(resp_b), 32'(RESP_OKAY));
        if (got_a == id0) begin
            compare_value("o_bid", 32'(got_b), 32'(id2));
        end else begin
            compare_value("o_bid", 32'(got_a), 32'(id2));
            compare_value("o_bid", 32'(got_b), 32'(id0));
        end
        @(posedge aclk);
        compare_value("o_bvalid", 32'(bvalid), 32'd0);
    endtask

    task automatic read_back_pressure();
        id_t id;
        int n;
        id = id_t'($random(seed));
        n = 0;
        rready <= 1'b0;
        drive_ar(WR_ADDR[1], id);
        while (!rvalid && n < WAIT_LIMIT) begin
            @(posedge aclk);
            n++;
        end
        if (!rvalid)
            stop_on_timeout("read response valid");
        for (int c = 0; c < 20; c++) begin
            @(posedge aclk);
            compare_value("o_rvalid", 32'(rvalid), 32'd1);
            compare_value("o_rid", 32'(rid), 32'(id));
            compare_value("o_rdata", 32'(rdata), 32'(wr_data[1]));
        end
        rready <= 1'b1;
        @(posedge aclk);
        compare_value("o_rvalid", 32'(rvalid), 32'd1);
        compare_value("o_rdata", 32'(rdata), 32'(wr_data[1]));
        rready <= 1'b0;
        @(posedge aclk);
        compare_value("o_rvalid", 32'(rvalid), 32'd0);
    endtask

    initial begin
        seed = 32'hf7fc_9e85;
        aresetn <= 1'b0;
        awvalid <= 1'b0;
        awaddr <= '0;
        awid <= '0;
        wvalid <= 1'b0;
        wdata <= '0;
        bready <= 1'b0;
        arvalid <= 1'b0;
        araddr <= '0;
        arid <= '0;
        rready <= 1'b0;
        b_hold <= '0;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        compare_value("o_bvalid", 32'(bvalid), 32'd0);
        compare_value("o_rvalid", 32'(rvalid), 32'd0);
        routed_writes();
        routed_reads();
        misrouted_writes();
        misrouted_reads();
        merged_responses();
        read_back_pressure();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/slv_switch_pkg.sv
logic/sync_fifo.sv
logic/rr_arbiter.sv
logic/addr_router.sv
logic/wdata_steer.sv
logic/resp_merger.sv
logic/slv_switch_top.sv
tests/slv_switch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the slave switch testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module slv_switch_tb \
    -Mdir obj_dir -o slv_switch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/slv_switch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
